/* design/nic_pkg.sv */
// NIC control core definitions
`default_nettype none

package nic_pkg;

    // --------------------------------------------------
    // Widths and time constants
    // --------------------------------------------------
    localparam int DATA_W    = 32;                        // APB data word
    localparam int ADDR_W    = 5;                         // APB byte address
    localparam int PTR_W     = 32;                        // Ring pointer
    localparam int HOLDOFF_W = 16;                        // Holdoff cycle count

    localparam logic [DATA_W-1:0] NS_PER_CYCLE = 32'd4;   // 250 MHz trn_clk
    localparam logic [DATA_W-1:0] NS_PER_SEC   = 32'd1_000_000_000; // Nsecs wrap point

    // --------------------------------------------------
    // Register map in byte offsets
    // --------------------------------------------------
    localparam logic [ADDR_W-1:0] REG_SW_PTR     = 5'h00; // RW software pointer
    localparam logic [ADDR_W-1:0] REG_HW_PTR     = 5'h04; // RO hardware pointer
    localparam logic [ADDR_W-1:0] REG_IRQ_CTRL   = 5'h08; // RW enable and holdoff
    localparam logic [ADDR_W-1:0] REG_IRQ_COUNT  = 5'h0C; // RO accepted interrupts
    localparam logic [ADDR_W-1:0] REG_TIME_NSECS = 5'h10; // RO nanoseconds
    localparam logic [ADDR_W-1:0] REG_TIME_SECS  = 5'h14; // RW seconds, load on write
    localparam logic [ADDR_W-1:0] REG_TIME_CTRL  = 5'h18; // RW bit 0 timestamp enable

    // --------------------------------------------------
    // Packed types
    // --------------------------------------------------
    typedef logic [PTR_W-1:0] ptr_t;

    typedef struct packed {
        logic              psel;                          // Slave select
        logic              penable;                       // Access phase
        logic              pwrite;                        // 1 write, 0 read
        logic [ADDR_W-1:0] paddr;
        logic [DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;                        // No wait states
        logic              pslverr;                       // Bad offset or RO write
    } apb_rsp_t;

    typedef struct packed {
        logic                 enable;                     // IRQ_CTRL bit 16
        logic [HOLDOFF_W-1:0] holdoff_cycles;             // IRQ_CTRL bits 15:0
    } irq_cfg_t;

    typedef struct packed {
        logic [DATA_W-HOLDOFF_W-2:0] rsvd;                // Reads as zero
        irq_cfg_t                    cfg;
    } irq_ctrl_fields_t;

    // Write word seen as a pointer or as interrupt control fields
    typedef union packed {
        ptr_t             ptr;
        irq_ctrl_fields_t ctrl;
    } ctrl_word_u;

    typedef struct packed {
        logic [DATA_W-1:0] secs;
        logic [DATA_W-1:0] nsecs;
    } sys_time_t;

    typedef enum logic [1:0] {
        IDLE    = 2'd0,                                   // Waiting for pointer mismatch
        ASSERT  = 2'd1,                                   // Request held low
        HOLDOFF = 2'd2                                    // Spacing before next request
    } irq_state_e;

endpackage

`default_nettype wire

/* design/irq_holdoff_timer.sv */
// Interrupt holdoff down-counter
`default_nettype none
`timescale 1ns/1ps

module irq_holdoff_timer import nic_pkg::*; (
    input  wire logic                 trn_clk,
    input  wire logic                 arst_n,
    input  wire logic                 load,               // Restart the interval
    input  wire logic [HOLDOFF_W-1:0] holdoff_cycles,     // Interval length
    output logic                      expired             // Sticky until next load
);

    logic [HOLDOFF_W-1:0] count;                          // Cycles left

    // --------------------------------------------------
    // Count down after each load
    // --------------------------------------------------
    // expired rises holdoff_cycles edges after the load edge,
    // one edge after when the interval is zero
    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            expired <= 1'b0;
        end else if (load) begin
            count   <= holdoff_cycles;
            expired <= 1'b0;
        end else if (!expired) begin
            if (count <= 1) begin
                count   <= '0;                            // Last cycle of the interval
                expired <= 1'b1;
            end else begin
                count   <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/interrupt_ctrl.sv */
// Interrupt request FSM
`default_nettype none
`timescale 1ns/1ps

module interrupt_ctrl import nic_pkg::*; (
    input  wire logic         trn_clk,
    input  wire logic         arst_n,
    input  wire irq_cfg_t     irq_cfg,                    // Enable and holdoff
    input  wire ptr_t         hw_ptr,                     // Receive datapath pointer
    input  wire ptr_t         sw_ptr,                     // Host pointer
    input  wire logic         cfg_interrupt_rdy_n,        // Endpoint accept, active low
    output logic              cfg_interrupt_n,            // Request, active low
    output logic [DATA_W-1:0] irq_count                   // Accepted interrupts
);

    // --------------------------------------------------
    // Local signals
    // --------------------------------------------------
    irq_state_e state;
    irq_state_e state_nxt;
    logic       ptr_diff;                                 // Host is behind
    logic       irq_ack;                                  // Endpoint took the request
    logic       hold_expired;                             // Holdoff interval done

    assign ptr_diff = (hw_ptr != sw_ptr);
    assign irq_ack  = (state == ASSERT) & ~cfg_interrupt_rdy_n;

    // --------------------------------------------------
    // Holdoff timer
    // --------------------------------------------------
    irq_holdoff_timer holdoff_i (
        .trn_clk        (trn_clk),                        // I
        .arst_n         (arst_n),                         // I
        .load           (irq_ack),                        // I loaded on accept
        .holdoff_cycles (irq_cfg.holdoff_cycles),         // I [15:0]
        .expired        (hold_expired)                    // O
    );

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (irq_cfg.enable && ptr_diff) begin
                    state_nxt = ASSERT;                   // Request next cycle
                end
            end
            ASSERT: begin
                if (irq_ack) begin
                    state_nxt = HOLDOFF;
                end
            end
            HOLDOFF: begin
                if (hold_expired) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;                    // Unused encoding
        endcase
    end

    // --------------------------------------------------
    // State, request and count
    // --------------------------------------------------
    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            state           <= IDLE;
            cfg_interrupt_n <= 1'b1;
            irq_count       <= '0;
        end else begin
            state           <= state_nxt;
            cfg_interrupt_n <= (state_nxt != ASSERT);     // Low only in ASSERT
            if (irq_ack) begin
                irq_count <= irq_count + 1'b1;            // Completed handshake
            end
        end
    end

endmodule

`default_nettype wire

/* design/sys_time.sv */
// Nanosecond and second system time
`default_nettype none
`timescale 1ns/1ps

module sys_time import nic_pkg::*; (
    input  wire logic              trn_clk,
    input  wire logic              arst_n,
    input  wire logic              secs_load,             // Host write strobe
    input  wire logic [DATA_W-1:0] secs_value,            // Written seconds
    output sys_time_t              sys_time
);

    // --------------------------------------------------
    // Nanosecond step and wrap
    // --------------------------------------------------
    logic [DATA_W-1:0] ns_next;                           // Nsecs after this cycle
    logic              ns_wrap;                           // One second reached

    assign ns_next = sys_time.nsecs + NS_PER_CYCLE;
    assign ns_wrap = (ns_next >= NS_PER_SEC);

    // --------------------------------------------------
    // Time counter
    // --------------------------------------------------
    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            sys_time <= '0;
        end else if (secs_load) begin
            // Host load restarts the second
            sys_time.secs  <= secs_value;
            sys_time.nsecs <= '0;
        end else if (ns_wrap) begin
            sys_time.secs  <= sys_time.secs + 1'b1;       // Carry into seconds
            sys_time.nsecs <= '0;
        end else begin
            sys_time.nsecs <= ns_next;                    // Free running
        end
    end

endmodule

`default_nettype wire

/* design/nic_host_regs.sv */
// APB host register block
`default_nettype none
`timescale 1ns/1ps

module nic_host_regs import nic_pkg::*; (
    input  wire logic              trn_clk,
    input  wire logic              arst_n,
    input  wire apb_req_t          apb_req,               // From host
    output apb_rsp_t               apb_rsp,               // To host
    input  wire ptr_t              hw_ptr,                // From receive datapath
    input  wire logic [DATA_W-1:0] irq_count,             // From interrupt_ctrl
    input  wire sys_time_t         sys_time,              // From sys_time
    output ptr_t                   sw_ptr,
    output irq_cfg_t               irq_cfg,
    output logic                   secs_load,             // One-cycle strobe
    output logic [DATA_W-1:0]      secs_value,
    output logic                   timestamp_en
);

    // --------------------------------------------------
    // Access decode
    // --------------------------------------------------
    logic       access;                                   // Access phase
    logic       wr_acc;                                   // Write access phase
    logic       mapped;                                   // Offset in the map
    logic       read_only;                                // Offset not writable
    logic       wr_ok;                                    // Write that lands
    ctrl_word_u wdata_u;                                  // Write word in two views
    ctrl_word_u rd_ctrl;                                  // IRQ_CTRL readback word

    assign access  = apb_req.psel & apb_req.penable;
    assign wr_acc  = access & apb_req.pwrite;
    assign wdata_u = apb_req.pwdata;

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b0;
        case (apb_req.paddr)
            REG_SW_PTR,
            REG_IRQ_CTRL,
            REG_TIME_SECS,
            REG_TIME_CTRL: read_only = 1'b0;
            REG_HW_PTR,
            REG_IRQ_COUNT,
            REG_TIME_NSECS: read_only = 1'b1;
            default: mapped = 1'b0;                       // Holes and unaligned
        endcase
    end

    assign wr_ok = wr_acc & mapped & ~read_only;

    // --------------------------------------------------
    // Writable registers
    // --------------------------------------------------
    always_ff @(posedge trn_clk or negedge arst_n) begin
        if (!arst_n) begin
            sw_ptr       <= '0;
            irq_cfg      <= '0;
            timestamp_en <= 1'b0;
        end else if (wr_ok) begin
            case (apb_req.paddr)
                REG_SW_PTR:    sw_ptr       <= wdata_u.ptr;      // Raw pointer view
                REG_IRQ_CTRL:  irq_cfg      <= wdata_u.ctrl.cfg; // Field view
                REG_TIME_CTRL: timestamp_en <= apb_req.pwdata[0];
                default: ;                                // Secs go to sys_time
            endcase
        end
    end

    // Seconds load lands at the edge ending the access phase
    assign secs_load  = wr_ok & (apb_req.paddr == REG_TIME_SECS);
    assign secs_value = apb_req.pwdata;

    // --------------------------------------------------
    // Read mux and response
    // --------------------------------------------------
    always_comb begin
        rd_ctrl           = '0;
        rd_ctrl.ctrl.cfg  = irq_cfg;                      // Reserved bits stay zero
    end

    always_comb begin
        apb_rsp.prdata = '0;                              // Unmapped reads zero
        case (apb_req.paddr)
            REG_SW_PTR:     apb_rsp.prdata = sw_ptr;
            REG_HW_PTR:     apb_rsp.prdata = hw_ptr;
            REG_IRQ_CTRL:   apb_rsp.prdata = rd_ctrl;
            REG_IRQ_COUNT:  apb_rsp.prdata = irq_count;
            REG_TIME_NSECS: apb_rsp.prdata = sys_time.nsecs;
            REG_TIME_SECS:  apb_rsp.prdata = sys_time.secs;
            REG_TIME_CTRL:  apb_rsp.prdata = {{(DATA_W-1){1'b0}}, timestamp_en};
            default: ;
        endcase
    end

    assign apb_rsp.pready  = 1'b1;                        // Zero wait states
    assign apb_rsp.pslverr = access & (~mapped | (apb_req.pwrite & read_only));

endmodule

`default_nettype wire

/* design/nic_irq_top.sv */
// NIC interrupt control core top
`default_nettype none
`timescale 1ns/1ps

module nic_irq_top import nic_pkg::*; (
    input  wire logic     trn_clk,
    input  wire logic     arst_n,
    input  wire apb_req_t apb_req,                        // Host register access
    output apb_rsp_t      apb_rsp,
    input  wire ptr_t     hw_ptr,                         // From receive datapath
    input  wire logic     cfg_interrupt_rdy_n,            // From endpoint
    output logic          cfg_interrupt_n,                // To endpoint
    output sys_time_t     sys_time,                       // Timestamp source
    output logic          timestamp_en
);

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------
    ptr_t              sw_ptr;                            // Host pointer
    irq_cfg_t          irq_cfg;                           // Enable and holdoff
    logic              secs_load;                         // Seconds write strobe
    logic [DATA_W-1:0] secs_value;
    logic [DATA_W-1:0] irq_count;                         // Readback count

    nic_host_regs host_regs_i (
        .trn_clk      (trn_clk),                          // I
        .arst_n       (arst_n),                           // I
        .apb_req      (apb_req),                          // I
        .apb_rsp      (apb_rsp),                          // O
        .hw_ptr       (hw_ptr),                           // I [31:0]
        .irq_count    (irq_count),                        // I [31:0]
        .sys_time     (sys_time),                         // I
        .sw_ptr       (sw_ptr),                           // O [31:0]
        .irq_cfg      (irq_cfg),                          // O
        .secs_load    (secs_load),                        // O
        .secs_value   (secs_value),                       // O [31:0]
        .timestamp_en (timestamp_en)                      // O
    );

    sys_time sys_time_i (
        .trn_clk    (trn_clk),                            // I
        .arst_n     (arst_n),                             // I
        .secs_load  (secs_load),                          // I
        .secs_value (secs_value),                         // I [31:0]
        .sys_time   (sys_time)                            // O
    );

    interrupt_ctrl interrupt_ctrl_i (
        .trn_clk             (trn_clk),                   // I
        .arst_n              (arst_n),                    // I
        .irq_cfg             (irq_cfg),                   // I
        .hw_ptr              (hw_ptr),                    // I [31:0]
        .sw_ptr              (sw_ptr),                    // I [31:0]
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),       // I
        .cfg_interrupt_n     (cfg_interrupt_n),           // O
        .irq_count           (irq_count)                  // O [31:0]
    );

endmodule

`default_nettype wire

/* test/tb_nic_irq.sv */
// NIC interrupt core testbench
`default_nettype none
`timescale 1ns/1ps

module tb_nic_irq import nic_pkg::*; ();

    // --------------------------------------------------
    // Run length and cycle budgets
    // --------------------------------------------------
    localparam int N_REG_OPS      = 80;                    // Random register accesses
    localparam int N_IRQS         = 6;                     // Handshakes in the IRQ test
    localparam int N_ROUNDS       = 4;                     // Holdoff values tried
    localparam int IRQ_WAIT_LIMIT = 90;                    // Cycles allowed for a request
    localparam int BUDGET_RESET   = 100;
    localparam int BUDGET_REGS    = N_REG_OPS * 4 + 50;
    localparam int BUDGET_TIME    = 100;
    localparam int BUDGET_IRQ     = N_IRQS * (IRQ_WAIT_LIMIT + 12) + 250;
    localparam int BUDGET_HOLDOFF = N_ROUNDS * (3 * (IRQ_WAIT_LIMIT + 12) + 10) + 50;
    localparam int WATCHDOG_CYCLES = 2 * (BUDGET_RESET + BUDGET_REGS + BUDGET_TIME
                                          + BUDGET_IRQ + BUDGET_HOLDOFF);

    logic      trn_clk;
    logic      arst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    ptr_t      hw_ptr;
    logic      cfg_interrupt_rdy_n;
    logic      cfg_interrupt_n;
    sys_time_t sys_time;
    logic      timestamp_en;

    nic_irq_top dut (
        .trn_clk             (trn_clk),
        .arst_n              (arst_n),
        .apb_req             (apb_req),
        .apb_rsp             (apb_rsp),
        .hw_ptr              (hw_ptr),
        .cfg_interrupt_rdy_n (cfg_interrupt_rdy_n),
        .cfg_interrupt_n     (cfg_interrupt_n),
        .sys_time            (sys_time),
        .timestamp_en        (timestamp_en)
    );

    // --------------------------------------------------
    // Register map model and bookkeeping
    // --------------------------------------------------
    ptr_t              m_sw_ptr;
    logic [DATA_W-1:0] m_irq_ctrl;                         // Bits 16:0 only
    logic [DATA_W-1:0] m_secs;
    logic              m_ts_en;
    logic [DATA_W-1:0] m_irq_count;                        // Completed handshakes
    int                ns_zero_cyc;                        // Cycle where nsecs was zero
    int                cyc = 0;                            // Edges since reset release
    logic [31:0]       lcg_state;
    int                errors = 0;
    int                checks = 0;
    int                n_tests = 0;
    int                test_errors0;
    int                test_checks0;

    initial begin
        trn_clk = 1'b0;
        forever #2 trn_clk = ~trn_clk;                     // 250 MHz
    end

    always @(posedge trn_clk) begin
        if (arst_n) cyc <= cyc + 1;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(input int n);
        return int'((next_random() >> 8) % n);             // Upper bits mix better
    endfunction

    function automatic bit is_mapped(input logic [ADDR_W-1:0] addr);
        return addr inside {REG_SW_PTR, REG_HW_PTR, REG_IRQ_CTRL, REG_IRQ_COUNT,
                            REG_TIME_NSECS, REG_TIME_SECS, REG_TIME_CTRL};
    endfunction

    function automatic bit is_read_only(input logic [ADDR_W-1:0] addr);
        return addr inside {REG_HW_PTR, REG_IRQ_COUNT, REG_TIME_NSECS};
    endfunction

    // Nanoseconds expected at a given cycle stamp
    function automatic logic [DATA_W-1:0] model_nsecs(input int stamp);
        logic [DATA_W-1:0] elapsed;
        elapsed = stamp - ns_zero_cyc;
        return elapsed * NS_PER_CYCLE;
    endfunction

    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr,
                                                     input int stamp);
        case (addr)
            REG_SW_PTR:     return m_sw_ptr;
            REG_HW_PTR:     return hw_ptr;                 // As driven by the testbench
            REG_IRQ_CTRL:   return m_irq_ctrl;
            REG_IRQ_COUNT:  return m_irq_count;
            REG_TIME_NSECS: return model_nsecs(stamp);
            REG_TIME_SECS:  return m_secs;
            REG_TIME_CTRL:  return {{(DATA_W-1){1'b0}}, m_ts_en};
            default:        return '0;                     // Holes read zero
        endcase
    endfunction

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_rsp(input apb_rsp_t got, input apb_rsp_t exp,
                             input bit cmp_data, input string what);
        checks++;
        if (got.pready !== exp.pready || got.pslverr !== exp.pslverr ||
            (cmp_data && got.prdata !== exp.prdata)) begin
            errors++;
            $display({"ERROR at %0t: %s got prdata %h pready %b pslverr %b,",
                      " expected prdata %h pready %b pslverr %b"}, $time, what,
                     got.prdata, got.pready, got.pslverr,
                     exp.prdata, exp.pready, exp.pslverr);
        end
    endtask

    task automatic check_time(input sys_time_t got, input sys_time_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %0d s %0d ns, expected %0d s %0d ns", $time,
                     what, got.secs, got.nsecs, exp.secs, exp.nsecs);
        end
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Request must stay high at least the programmed interval
    task automatic check_holdoff(input int gap, input logic [HOLDOFF_W-1:0] hold);
        checks++;
        if (gap < hold) begin
            errors++;
            $display("ERROR at %0t: request high %0d cycles, holdoff %0d",
                     $time, gap, hold);
        end
    endtask

    // --------------------------------------------------
    // APB access with setup then one access phase
    // --------------------------------------------------
    task automatic apb_xfer(input bit write, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, output apb_rsp_t rsp,
                            output int stamp);
        @(negedge trn_clk);
        apb_req.psel    = 1'b1;                            // Setup
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge trn_clk);
        apb_req.penable = 1'b1;                            // Access
        #1;
        rsp   = apb_rsp;                                   // Settled before the edge
        stamp = cyc;
        @(negedge trn_clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    // Access checked against the model before the model takes the write
    task automatic reg_access(input bit write, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data);
        apb_rsp_t got;
        apb_rsp_t exp;
        int       stamp;
        bit       bad;
        bad = !is_mapped(addr) || (write && is_read_only(addr));
        apb_xfer(write, addr, data, got, stamp);
        exp.pready  = 1'b1;
        exp.pslverr = bad;
        exp.prdata  = model_read(addr, stamp);
        check_rsp(got, exp, !write, $sformatf("%s 0x%02h", write ? "write" : "read", addr));
        if (write && !bad) begin
            case (addr)
                REG_SW_PTR:    m_sw_ptr   = data;
                REG_IRQ_CTRL:  m_irq_ctrl = data & 32'h0001_FFFF;
                REG_TIME_SECS: begin
                    m_secs      = data;
                    ns_zero_cyc = cyc;                     // Load edge already counted
                end
                REG_TIME_CTRL: begin
                    m_ts_en = data[0];
                    check_bit(timestamp_en, data[0], "timestamp_en");
                end
                default: ;
            endcase
        end
    endtask

    task automatic check_irq_count();
        apb_rsp_t got;
        int       stamp;
        apb_xfer(1'b0, REG_IRQ_COUNT, '0, got, stamp);
        check_word(got.prdata, m_irq_count, "IRQ_COUNT");
    endtask

    // --------------------------------------------------
    // Interrupt handshake and quiet window
    // --------------------------------------------------
    task automatic irq_handshake(output int gap);
        int waited;
        waited = 0;
        while (cfg_interrupt_n === 1'b1 && waited <= IRQ_WAIT_LIMIT) begin
            @(negedge trn_clk);
            waited++;                                      // Cycles the request stayed high
        end
        gap = waited;
        if (cfg_interrupt_n !== 1'b0) begin
            errors++;
            $display("Interrupt request did not assert within %0d cycles", IRQ_WAIT_LIMIT);
        end else begin
            repeat (random_below(8)) begin                 // Endpoint back-pressure
                @(negedge trn_clk);
                check_bit(cfg_interrupt_n, 1'b0, "cfg_interrupt_n while waiting");
            end
            cfg_interrupt_rdy_n = 1'b0;
            @(negedge trn_clk);
            cfg_interrupt_rdy_n = 1'b1;
            m_irq_count++;
            check_bit(cfg_interrupt_n, 1'b1, "cfg_interrupt_n after accept");
        end
    endtask

    task automatic quiet_window(input int cycles, input string what);
        logic quiet;
        quiet = 1'b1;
        repeat (cycles) begin
            @(negedge trn_clk);
            quiet &= cfg_interrupt_n;
        end
        check_bit(quiet, 1'b1, what);
    endtask

    task automatic begin_test();
        test_errors0 = errors;
        test_checks0 = checks;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("Test %s done: %0d checks, %0d errors", name,
                 checks - test_checks0, errors - test_errors0);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        sys_time_t exp_time;
        apb_rsp_t  rsp1;
        apb_rsp_t  rsp2;
        int        stamp1;
        int        stamp2;
        int        gap;
        int        hold;
        arst_n = 1'b0;
        apb_req = '0;
        hw_ptr = '0;
        cfg_interrupt_rdy_n = 1'b1;
        lcg_state = 32'd36497;
        m_sw_ptr = '0;
        m_irq_ctrl = '0;
        m_secs = '0;
        m_ts_en = 1'b0;
        m_irq_count = '0;
        ns_zero_cyc = 0;
        repeat (3) @(posedge trn_clk);
        @(negedge trn_clk);
        arst_n = 1'b1;

        begin_test();
        check_bit(cfg_interrupt_n, 1'b1, "cfg_interrupt_n after reset");
        check_bit(timestamp_en, 1'b0, "timestamp_en after reset");
        check_bit(apb_rsp.pslverr, 1'b0, "pslverr after reset");
        for (int i = 0; i < 7; i++) reg_access(1'b0, ADDR_W'(i * 4), '0);
        exp_time.secs  = m_secs;
        exp_time.nsecs = model_nsecs(cyc);
        check_time(sys_time, exp_time, "sys_time after reset");
        end_test("reset");

        begin_test();
        for (int i = 0; i < N_REG_OPS; i++) begin
            if (random_below(8) == 0) hw_ptr = next_random();
            if (random_below(4) == 0) begin
                reg_access(random_below(2), ADDR_W'(random_below(32)), next_random());
            end else begin                                 // Aligned and mostly mapped
                reg_access(random_below(2), ADDR_W'(random_below(8) * 4), next_random());
            end
        end
        end_test("register access");

        begin_test();
        reg_access(1'b1, REG_TIME_SECS, next_random());
        reg_access(1'b0, REG_TIME_SECS, '0);
        exp_time.secs  = m_secs;
        exp_time.nsecs = model_nsecs(cyc);
        check_time(sys_time, exp_time, "sys_time after seconds load");
        apb_xfer(1'b0, REG_TIME_NSECS, '0, rsp1, stamp1);
        repeat (random_below(10)) @(negedge trn_clk);
        apb_xfer(1'b0, REG_TIME_NSECS, '0, rsp2, stamp2);
        check_word(rsp1.prdata, model_nsecs(stamp1), "first NSECS read");
        check_word(rsp2.prdata - rsp1.prdata, (stamp2 - stamp1) * NS_PER_CYCLE,
                   "NSECS step between reads");
        end_test("system time");

        begin_test();
        reg_access(1'b1, REG_IRQ_CTRL, 32'h0001_0000 | random_below(16));
        reg_access(1'b1, REG_SW_PTR, next_random());
        hw_ptr = m_sw_ptr + 1 + random_below(1000);
        repeat (N_IRQS) irq_handshake(gap);
        hw_ptr = m_sw_ptr;                                 // Host caught up
        check_irq_count();
        quiet_window(50, "cfg_interrupt_n with equal pointers");
        reg_access(1'b1, REG_IRQ_CTRL, random_below(16));  // Enable off
        hw_ptr = m_sw_ptr + 1 + random_below(1000);
        quiet_window(50, "cfg_interrupt_n with interrupt disabled");
        end_test("interrupt handshake");

        begin_test();
        for (int r = 0; r < N_ROUNDS; r++) begin
            hold = random_below(64);
            reg_access(1'b1, REG_IRQ_CTRL, 32'h0001_0000 | hold);
            hw_ptr = m_sw_ptr + 1 + random_below(1000);
            irq_handshake(gap);                            // Loads the new interval
            repeat (2) begin
                irq_handshake(gap);
                check_holdoff(gap, HOLDOFF_W'(hold));
            end
        end
        hw_ptr = m_sw_ptr;
        check_irq_count();
        end_test("holdoff");

        $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog over twice the summed test budgets
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge trn_clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
design/nic_pkg.sv
design/irq_holdoff_timer.sv
design/interrupt_ctrl.sv
design/sys_time.sv
design/nic_host_regs.sv
design/nic_irq_top.sv
test/tb_nic_irq.sv
